// ==== design/vdc_access_pkg.sv ====
// ====================
// VDC memory access types
// CPU actions and RAM slot owners
// ====================
`default_nettype none

package vdc_access_pkg;

	// pending indirect memory action
	typedef enum logic [2:0] {
		CA_NONE,
		CA_READ,
		CA_WRITE,
		CA_FILL,
		CA_COPY0,  // read source byte
		CA_COPY1   // write it to destination
	} cpu_action_e;

	// owner of the current column slot
	typedef enum logic [2:0] {
		RA_NONE,
		RA_CHAR,
		RA_SCRN,
		RA_ATTR,
		RA_CPU
	} ram_action_e;

endpackage

`default_nettype wire

// ==== design/vdc_mem_if.sv ====
// ====================
// VDC CPU memory channel
// ====================
`default_nettype none

interface vdc_mem_if import vdc_access_pkg::*; ();
	cpu_action_e req;
	logic [15:0] ua;
	logic [15:0] ba;
	logic [7:0]  wdata;
	logic [7:0]  wc;
	logic        step;   // slot for req finished
	logic [7:0]  rdata;

	modport regs_side (output req, ua, ba, wdata, wc, input step, rdata);
	modport ram_side (input req, ua, ba, wdata, wc, output step, rdata);
endinterface

`default_nettype wire

// ==== design/vdc_params.svh ====
// ====================
// VDC build constants
// RAM size, row buffer depth and column timing
// ====================
`ifndef VDC_PARAMS_SVH
`define VDC_PARAMS_SVH

// 16 KiB video RAM
`define VDC_RAM_ABITS 14

// row buffer depth, max displayed columns
`define VDC_LATCH_W 80

// character bitmap latch depth
`define VDC_CHAR_LATCH_W 8

// clocks per character column
`define VDC_COL_CLKS 4

`endif

// ==== design/vdc_ram.sv ====
// ====================
// VDC video RAM
// single port, registered read
// ====================
`default_nettype none

`include "vdc_params.svh"

module vdc_ram (
	input  logic                      clk,
	input  logic                      rd,
	input  logic                      we,
	input  logic [`VDC_RAM_ABITS-1:0] addr,
	input  logic [7:0]                wdata,
	output logic [7:0]                rdata
);
	logic [7:0] mem [2**`VDC_RAM_ABITS];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		if (rd)
			rdata <= mem[addr];  // valid the cycle after rd
	end

endmodule

`default_nettype wire

// ==== design/vdc_ramiface.sv ====
// ====================
// VDC RAM interface
// one RAM slot per column shared by display fetch and CPU
// ====================
`default_nettype none

`include "vdc_params.svh"

module vdc_ramiface import vdc_reg_pkg::*, vdc_access_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      col_start,
	input  logic                      col_end,
	input  logic                      new_line,
	input  logic                      new_row,
	input  logic                      v_visible,
	input  logic [7:0]                col,
	input  logic [7:0]                row,
	input  logic [4:0]                line,
	input  logic [7:0]                hd,
	input  logic [7:0]                ht,
	input  logic [15:0]               ds,
	input  logic [15:0]               aa,
	input  logic [7:0]                ai,
	input  logic [2:0]                cb,
	input  logic [4:0]                ctv,
	input  mode_bits_t                mode,
	vdc_mem_if.ram_side               mem,
	output logic                      ram_rd,
	output logic                      ram_we,
	output logic [`VDC_RAM_ABITS-1:0] ram_addr,
	output logic [7:0]                ram_wdata,
	input  logic [7:0]                ram_rdata,
	output logic [7:0]                cur_code,
	output logic [7:0]                cur_attr,
	output logic [7:0]                char_byte,
	output logic                      char_valid
);
	localparam int IW        = $clog2(`VDC_LATCH_W);
	localparam int CIW       = $clog2(`VDC_CHAR_LATCH_W);
	localparam int RFSH_COLS = 5;  // refresh columns right after the display

	logic [7:0]     scrn_buf [2][`VDC_LATCH_W];
	logic [7:0]     attr_buf [2][`VDC_LATCH_W];
	logic [7:0]     char_buf [`VDC_CHAR_LATCH_W];
	logic           row_buf;       // buffer holding the current row
	logic           rb_now;
	logic [IW-1:0]  scrn_idx;
	logic [IW-1:0]  attr_idx;
	logic [IW-1:0]  col_idx;
	logic [IW-1:0]  out_col;
	logic [CIW-1:0] char_idx;
	logic [CIW-1:0] out_idx;
	logic [15:0]    scrn_addr;     // next row's screen codes
	logic [15:0]    attr_addr;
	logic [15:0]    stride;
	logic [15:0]    scrn_next;
	logic [15:0]    attr_next;
	logic [15:0]    char_addr;
	logic [15:0]    slot_addr;
	logic [7:0]     code_now;
	logic [7:0]     attr_now;
	logic           attr_bit;
	logic           col_in;
	logic           en_rfsh;
	logic           en_scac;
	logic           cpu_ready;
	logic           slot_rd;
	logic           slot_we;
	ram_action_e    ram_action;
	ram_action_e    slot_action;

	// new_row swaps the buffers on this same edge
	assign rb_now   = row_buf ^ new_row;
	assign col_idx  = col[IW-1:0];
	assign col_in   = (col < 8'(`VDC_LATCH_W));
	assign code_now = scrn_buf[rb_now][col_idx];
	assign attr_now = attr_buf[rb_now][col_idx];
	assign attr_bit = mode.attr_en & attr_now[7];  // second character set
	assign char_addr = ctv[4] ? {cb[2:1], attr_bit, code_now, line[4:0]}
	                          : {cb, attr_bit, code_now, line[3:0]};

	assign stride    = 16'(hd) + 16'(ai);
	assign scrn_next = v_visible ? ((row == 8'd0) ? ds : scrn_addr) + stride : ds;
	assign attr_next = v_visible ? ((row == 8'd0) ? aa : attr_addr) + stride : aa;

	assign en_rfsh = ({1'b0, col} >= {1'b0, hd}) && ({1'b0, col} < {1'b0, hd} + 9'(RFSH_COLS));
	assign en_scac = !en_rfsh && (col >= 8'd2) && ({1'b0, col} + 9'd2 <= {1'b0, ht});
	assign cpu_ready = (mem.req != CA_NONE) &&
	                   ((mem.wc != 8'd0) || (mem.req inside {CA_READ, CA_WRITE}));

	always_comb begin
		slot_action = RA_NONE;
		slot_addr   = 16'h0000;
		slot_rd     = 1'b0;
		slot_we     = 1'b0;
		if (v_visible && col < hd && col_in) begin
			slot_action = RA_CHAR;
			slot_addr   = char_addr;
			slot_rd     = 1'b1;
		end else if (en_scac && scrn_idx < hd && scrn_idx < IW'(`VDC_LATCH_W)) begin
			slot_action = RA_SCRN;
			slot_addr   = scrn_addr + 16'(scrn_idx);
			slot_rd     = 1'b1;
		end else if (en_scac && mode.attr_en && attr_idx < hd
		             && attr_idx < IW'(`VDC_LATCH_W)) begin
			slot_action = RA_ATTR;
			slot_addr   = attr_addr + 16'(attr_idx);
			slot_rd     = 1'b1;
		end else if (!en_rfsh && cpu_ready) begin
			slot_action = RA_CPU;
			slot_addr   = (mem.req == CA_COPY0) ? mem.ba : mem.ua;
			slot_rd     = mem.req inside {CA_READ, CA_COPY0};
			slot_we     = !slot_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ram_rd     <= 1'b0;
			ram_we     <= 1'b0;
			ram_action <= RA_NONE;
			row_buf    <= 1'b0;
			scrn_idx   <= '0;
			attr_idx   <= '0;
			char_idx   <= '0;
			scrn_addr  <= 16'h0000;
			attr_addr  <= 16'h0000;
			char_valid <= 1'b0;
		end else begin
			ram_rd     <= col_start & slot_rd;
			ram_we     <= col_start & slot_we;
			char_valid <= col_end && (ram_action == RA_CHAR);
			if (col_start) begin
				ram_action <= slot_action;
				if (new_row) begin
					row_buf   <= ~row_buf;
					scrn_idx  <= '0;
					attr_idx  <= '0;
					scrn_addr <= scrn_next;
					attr_addr <= attr_next;
				end
				if (new_line)
					char_idx <= '0;
			end
			if (col_end) begin
				case (ram_action)
					RA_CHAR: char_idx <= CIW'((char_idx + 1) % `VDC_CHAR_LATCH_W);
					RA_SCRN: scrn_idx <= scrn_idx + 1'b1;
					RA_ATTR: attr_idx <= attr_idx + 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (col_start) begin
			ram_addr  <= slot_addr[`VDC_RAM_ABITS-1:0];
			ram_wdata <= mem.wdata;
		end
		if (col_end) begin
			case (ram_action)
				RA_CHAR: begin
					char_buf[char_idx] <= ram_rdata;
					out_idx            <= char_idx;
					out_col            <= col_idx;  // column shown next cycle
				end
				RA_SCRN: scrn_buf[~row_buf][scrn_idx] <= ram_rdata;
				RA_ATTR: attr_buf[~row_buf][attr_idx] <= ram_rdata;
				default: ;
			endcase
		end
	end

	assign mem.step  = col_end && (ram_action == RA_CPU);
	assign mem.rdata = ram_rdata;

	assign char_byte = char_buf[out_idx];
	assign cur_code  = scrn_buf[row_buf][out_col];
	assign cur_attr  = mode.attr_en ? attr_buf[row_buf][out_col] : 8'h00;

endmodule

`default_nettype wire

// ==== design/vdc_reg_pkg.sv ====
// ====================
// VDC register map
// register indices and mode bits
// ====================
`default_nettype none

package vdc_reg_pkg;

	typedef enum logic [5:0] {
		R_HT    = 6'd0,   // horizontal total
		R_HD    = 6'd1,   // horizontal displayed
		R_VT    = 6'd4,   // vertical total in rows
		R_VD    = 6'd6,   // vertical displayed
		R_CTV   = 6'd9,   // lines per row minus one
		R_DS_HI = 6'd12,
		R_DS_LO = 6'd13,
		R_UA_HI = 6'd18,
		R_UA_LO = 6'd19,
		R_AA_HI = 6'd20,
		R_AA_LO = 6'd21,
		R_MODE  = 6'd24,
		R_AI    = 6'd27,  // row address increment
		R_CB    = 6'd28,  // character base
		R_WC    = 6'd30,
		R_DA    = 6'd31,
		R_BA_HI = 6'd32,
		R_BA_LO = 6'd33
	} reg_addr_e;

	typedef struct packed {
		logic copy;       // block copy instead of fill
		logic attr_en;
		logic text;
	} mode_bits_t;

endpackage

`default_nettype wire

// ==== design/vdc_regs.sv ====
// ====================
// VDC register port
// Wishbone slave with display and indirect memory registers
// ====================
`default_nettype none

module vdc_regs import vdc_reg_pkg::*, vdc_access_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [5:0]  wb_adr,
	input  logic [7:0]  wb_dat_i,
	output logic [7:0]  wb_dat_o,
	output logic        wb_ack,
	vdc_mem_if.regs_side mem,
	output logic [7:0]  ht,
	output logic [7:0]  hd,
	output logic [7:0]  vt,
	output logic [7:0]  vd,
	output logic [4:0]  ctv,
	output logic [15:0] ds,
	output logic [15:0] aa,
	output logic [7:0]  ai,
	output logic [2:0]  cb,
	output mode_bits_t  mode,
	output logic        busy
);
	cpu_action_e action;
	reg_addr_e   addr;
	logic [15:0] ua;
	logic [15:0] ba;
	logic [7:0]  wc;
	logic [7:0]  da;      // last byte read from RAM
	logic [7:0]  wda;     // byte written through DA, also fill value
	logic [7:0]  cda;     // copy byte in flight
	logic [7:0]  rd_mux;
	logic        bus_req;
	logic        indirect;
	logic        take;

	assign addr     = reg_addr_e'(wb_adr);
	assign bus_req  = wb_cyc & wb_stb & ~wb_ack;
	assign indirect = addr inside {R_UA_HI, R_UA_LO, R_WC, R_DA};
	assign take     = bus_req & ~(busy & indirect);  // hold off until RAM side is idle
	assign busy     = (action != CA_NONE);

	assign mem.req   = action;
	assign mem.ua    = ua;
	assign mem.ba    = ba;
	assign mem.wc    = wc;
	assign mem.wdata = (action == CA_COPY1) ? cda : wda;

	always_comb begin
		case (addr)
			R_HT:    rd_mux = ht;
			R_HD:    rd_mux = hd;
			R_VT:    rd_mux = vt;
			R_VD:    rd_mux = vd;
			R_CTV:   rd_mux = {3'b000, ctv};
			R_DS_HI: rd_mux = ds[15:8];
			R_DS_LO: rd_mux = ds[7:0];
			R_UA_HI: rd_mux = ua[15:8];
			R_UA_LO: rd_mux = ua[7:0];
			R_AA_HI: rd_mux = aa[15:8];
			R_AA_LO: rd_mux = aa[7:0];
			R_MODE:  rd_mux = {5'b00000, mode};
			R_AI:    rd_mux = ai;
			R_CB:    rd_mux = {5'b00000, cb};
			R_WC:    rd_mux = wc;
			R_DA:    rd_mux = da;
			R_BA_HI: rd_mux = ba[15:8];
			R_BA_LO: rd_mux = ba[7:0];
			default: rd_mux = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			ht     <= 8'h1F;
			hd     <= 8'd0;
			vt     <= 8'h20;
			vd     <= 8'd0;
			ctv    <= 5'd0;
			ds     <= 16'h0000;
			aa     <= 16'h0000;
			ai     <= 8'd0;
			cb     <= 3'd0;
			mode   <= '0;
			ua     <= 16'h0000;
			ba     <= 16'h0000;
			wc     <= 8'd0;
			da     <= 8'd0;
			wda    <= 8'd0;
			cda    <= 8'd0;
			action <= CA_NONE;
		end else begin
			wb_ack <= take;
			if (mem.step) begin
				case (action)
					CA_READ: begin
						da     <= mem.rdata;
						action <= CA_NONE;
					end
					CA_WRITE: begin
						ua     <= ua + 16'd1;
						action <= CA_READ;  // DA follows the new UA
					end
					CA_FILL: begin
						ua     <= ua + 16'd1;
						wc     <= wc - 8'd1;
						action <= (wc == 8'd1) ? CA_NONE : CA_FILL;
					end
					CA_COPY0: begin
						cda    <= mem.rdata;
						ba     <= ba + 16'd1;
						action <= CA_COPY1;
					end
					CA_COPY1: begin
						ua     <= ua + 16'd1;
						wc     <= wc - 8'd1;
						action <= (wc == 8'd1) ? CA_NONE : CA_COPY0;
					end
					default: ;
				endcase
			end
			if (take && wb_we) begin
				case (addr)
					R_HT:    ht <= wb_dat_i;
					R_HD:    hd <= wb_dat_i;
					R_VT:    vt <= wb_dat_i;
					R_VD:    vd <= wb_dat_i;
					R_CTV:   ctv <= wb_dat_i[4:0];
					R_DS_HI: ds[15:8] <= wb_dat_i;
					R_DS_LO: ds[7:0] <= wb_dat_i;
					R_UA_HI: begin
						ua[15:8] <= wb_dat_i;
						action   <= CA_READ;
					end
					R_UA_LO: begin
						ua[7:0] <= wb_dat_i;
						action  <= CA_READ;
					end
					R_AA_HI: aa[15:8] <= wb_dat_i;
					R_AA_LO: aa[7:0] <= wb_dat_i;
					R_MODE:  mode <= mode_bits_t'(wb_dat_i[2:0]);
					R_AI:    ai <= wb_dat_i;
					R_CB:    cb <= wb_dat_i[2:0];
					R_WC: begin
						wc <= wb_dat_i;
						if (wb_dat_i != 8'd0)  // zero count moves nothing
							action <= mode.copy ? CA_COPY0 : CA_FILL;
					end
					R_DA: begin
						wda    <= wb_dat_i;
						action <= CA_WRITE;
					end
					R_BA_HI: ba[15:8] <= wb_dat_i;
					R_BA_LO: ba[7:0] <= wb_dat_i;
					default: ;
				endcase
			end else if (take && addr == R_DA) begin
				ua     <= ua + 16'd1;  // prefetch next byte
				action <= CA_READ;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && !wb_we)
			wb_dat_o <= rd_mux;
	end

endmodule

`default_nettype wire

// ==== design/vdc_timing.sv ====
// ====================
// VDC timing generator
// column, line and row counters with slot strobes
// ====================
`default_nettype none

`include "vdc_params.svh"

module vdc_timing (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] ht,
	input  logic [7:0] hd,
	input  logic [7:0] vt,
	input  logic [7:0] vd,
	input  logic [4:0] ctv,
	output logic       col_start,
	output logic       col_end,
	output logic       new_line,
	output logic       new_row,
	output logic       v_visible,
	output logic [7:0] col,
	output logic [7:0] row,
	output logic [4:0] line
);
	localparam int CW = $clog2(`VDC_COL_CLKS);

	logic [CW-1:0] div;  // clock within column

	always_ff @(posedge clk) begin
		if (reset) begin
			div  <= '0;
			col  <= 8'd0;
			line <= 5'd0;
			row  <= 8'd0;
		end else begin
			div <= col_end ? '0 : div + 1'b1;
			if (col_end) begin
				if (col >= ht) begin
					col <= 8'd0;
					if (line >= ctv) begin
						line <= 5'd0;
						row  <= (row >= vt) ? 8'd0 : row + 8'd1;
					end else begin
						line <= line + 5'd1;
					end
				end else begin
					col <= col + 8'd1;
				end
			end
		end
	end

	assign col_start = (div == '0);
	assign col_end   = (div == CW'(`VDC_COL_CLKS - 1));
	assign new_line  = col_start && (col == 8'd0);
	assign new_row   = new_line && (line == 5'd0);

	// no displayed columns means the row is blank
	assign v_visible = (row < vd) && (hd != 8'd0);

endmodule

`default_nettype wire

// ==== design/vdc_top.sv ====
// ====================
// VDC top level
// timing, registers, RAM interface, RAM and video output
// ====================
`default_nettype none

`include "vdc_params.svh"

module vdc_top import vdc_reg_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  logic [5:0] wb_adr,
	input  logic [7:0] wb_dat_i,
	output logic [7:0] wb_dat_o,
	output logic       wb_ack,
	output logic       busy,
	output logic       vid_valid,
	output logic [7:0] vid_code,
	output logic [7:0] vid_attr,
	output logic [7:0] vid_bits
);
	logic [7:0]                ht, hd, vt, vd, ai;
	logic [4:0]                ctv;
	logic [15:0]               ds, aa;
	logic [2:0]                cb;
	mode_bits_t                mode;
	logic                      col_start, col_end, new_line, new_row, v_visible;
	logic [7:0]                col, row;
	logic [4:0]                line;
	logic                      ram_rd, ram_we;
	logic [`VDC_RAM_ABITS-1:0] ram_addr;
	logic [7:0]                ram_wdata, ram_rdata;
	logic [7:0]                cur_code, cur_attr, char_byte;
	logic                      char_valid;

	vdc_mem_if mem ();

	vdc_timing i_timing (
		.clk(clk), .reset(reset),
		.ht(ht), .hd(hd), .vt(vt), .vd(vd), .ctv(ctv),
		.col_start(col_start), .col_end(col_end),
		.new_line(new_line), .new_row(new_row), .v_visible(v_visible),
		.col(col), .row(row), .line(line)
	);

	vdc_regs i_regs (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.mem(mem),
		.ht(ht), .hd(hd), .vt(vt), .vd(vd), .ctv(ctv),
		.ds(ds), .aa(aa), .ai(ai), .cb(cb), .mode(mode), .busy(busy)
	);

	vdc_ramiface i_ramiface (
		.clk(clk), .reset(reset),
		.col_start(col_start), .col_end(col_end),
		.new_line(new_line), .new_row(new_row), .v_visible(v_visible),
		.col(col), .row(row), .line(line),
		.hd(hd), .ht(ht), .ds(ds), .aa(aa), .ai(ai), .cb(cb), .ctv(ctv), .mode(mode),
		.mem(mem),
		.ram_rd(ram_rd), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
		.cur_code(cur_code), .cur_attr(cur_attr),
		.char_byte(char_byte), .char_valid(char_valid)
	);

	vdc_ram i_ram (
		.clk(clk), .rd(ram_rd), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

	always_ff @(posedge clk) begin
		if (reset)
			vid_valid <= 1'b0;
		else
			vid_valid <= char_valid;
	end

	always_ff @(posedge clk) begin
		if (char_valid) begin
			vid_code <= cur_code;
			vid_attr <= cur_attr;
			vid_bits <= char_byte;  // bitmap row of this column
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the VDC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module vdc_tb \
	--Mdir obj_dir -o vdc_sim
./obj_dir/vdc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1

// ==== tb.f ====
+incdir+design
+incdir+test
design/vdc_reg_pkg.sv
design/vdc_access_pkg.sv
design/vdc_mem_if.sv
design/vdc_ram.sv
design/vdc_timing.sv
design/vdc_regs.sv
design/vdc_ramiface.sv
design/vdc_top.sv
test/vdc_tb.sv

// ==== test/vdc_model.svh ====
// ====================
// VDC reference model
// RAM mirror, address shadows and expected video bytes
// ====================
`ifndef VDC_MODEL_SVH
`define VDC_MODEL_SVH

logic [7:0]  mirror [2**`VDC_RAM_ABITS];
logic [15:0] ua_sh;   // expected UA
logic [15:0] ba_sh;   // expected BA

function automatic int ram_index(input logic [15:0] a);
	return int'(a) % (2**`VDC_RAM_ABITS);  // RAM sees the low address bits
endfunction

// bitmap address of one character line
function automatic logic [15:0] char_addr_of(input logic [2:0] cb, input logic attr_en,
		input logic [7:0] attr, input logic [7:0] code, input int line);
	logic [3:0] l;
	l = 4'(line);
	return {cb, attr_en & attr[7], code, l};
endfunction

function automatic logic [7:0] mirror_at(input logic [15:0] a);
	return mirror[ram_index(a)];
endfunction

task automatic model_write(input logic [7:0] v);
	mirror[ram_index(ua_sh)] = v;
	ua_sh = ua_sh + 16'd1;
endtask

task automatic model_fill(input logic [7:0] v, input int n);
	for (int i = 0; i < n; i++)
		model_write(v);
endtask

// source is read through BA, destination written through UA
task automatic model_copy(input int n);
	for (int i = 0; i < n; i++) begin
		model_write(mirror_at(ba_sh));
		ba_sh = ba_sh + 16'd1;
	end
endtask

`endif

// ==== test/vdc_tb.sv ====
// ====================
// VDC testbench
// random register and memory traffic checked against a model
// ====================
`default_nettype none

`include "vdc_params.svh"

module vdc_tb import vdc_reg_pkg::*; ();
	localparam int ACK_LIMIT  = 5000;
	localparam int IDLE_LIMIT = 5000;
	localparam int VID_LIMIT  = 20000;
	localparam int FRAME_GAP  = 400;  // longer than any gap inside a frame

	logic       clk;
	logic       reset;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [5:0] wb_adr;
	logic [7:0] wb_dat_i;
	logic [7:0] wb_dat_o;
	logic       wb_ack;
	logic       busy;
	logic       vid_valid;
	logic [7:0] vid_code;
	logic [7:0] vid_attr;
	logic [7:0] vid_bits;

	logic [31:0] rng;
	int          checks;
	int          errors;
	int          t_checks;
	int          t_errors;

	`include "vdc_model.svh"

	vdc_top i_dut (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.busy(busy),
		.vid_valid(vid_valid), .vid_code(vid_code), .vid_attr(vid_attr),
		.vid_bits(vid_bits)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic get_rand(output logic [7:0] v);
		rng = xorshift32(rng);
		v   = rng[15:8];
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		errors++;
		t_errors++;
	endtask

	task automatic check_val(input string sig, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		t_checks++;
		assert (act === exp) else begin
			$display("FAILED %0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
			t_errors++;
		end
	endtask

	task automatic start_test();
		t_checks = 0;
		t_errors = 0;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, t_checks, t_errors);
	endtask

	task automatic bus_release();
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wait_ack(input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < ACK_LIMIT);
		if (!wb_ack)
			report_timeout(what);
	endtask

	task automatic wb_write(input logic [5:0] adr, input logic [7:0] dat);
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_i <= dat;
		wait_ack("no ack on register write");
		bus_release();
	endtask

	task automatic wb_read(input logic [5:0] adr, output logic [7:0] dat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		wait_ack("no ack on register read");
		dat = wb_dat_o;
		bus_release();
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (busy && n < IDLE_LIMIT);
		if (busy)
			report_timeout("busy never fell");
	endtask

	task automatic set_ua(input logic [15:0] a);
		wb_write(R_UA_HI, a[15:8]);
		wb_write(R_UA_LO, a[7:0]);
		ua_sh = a;
		wait_idle();
	endtask

	task automatic set_ba(input logic [15:0] a);
		wb_write(R_BA_HI, a[15:8]);
		wb_write(R_BA_LO, a[7:0]);
		ba_sh = a;
	endtask

	task automatic read_pair(input logic [5:0] hi, input logic [5:0] lo,
			output logic [15:0] v);
		logic [7:0] h;
		logic [7:0] l;
		wb_read(hi, h);
		wb_read(lo, l);
		v = {h, l};
	endtask

	task automatic mem_write(input logic [7:0] v);
		wb_write(R_DA, v);
		model_write(v);
	endtask

	task automatic mem_read_check(input int n);
		logic [7:0] v;
		for (int i = 0; i < n; i++) begin
			wb_read(R_DA, v);
			check_val("wb_dat_o (DA)", mirror_at(ua_sh), v);
			ua_sh = ua_sh + 16'd1;
		end
	endtask

	task automatic wait_vid();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!vid_valid && n < VID_LIMIT);
		if (!vid_valid)
			report_timeout("no vid_valid pulse");
	endtask

	// returns on the first pulse after a blank frame gap
	task automatic wait_frame_start();
		int quiet;
		int n;
		logic found;
		wait_vid();
		quiet = 0;
		n     = 0;
		found = 1'b0;
		while (!found && n < 4 * VID_LIMIT) begin
			@(negedge clk);
			n++;
			if (vid_valid) begin
				if (quiet > FRAME_GAP)
					found = 1'b1;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		if (!found)
			report_timeout("no frame start found");
	endtask

	task automatic test_regs();
		logic [7:0]  v;
		logic [15:0] a;
		logic [15:0] got;
		start_test();
		check_val("busy", 16'd0, busy);
		check_val("vid_valid", 16'd0, vid_valid);
		check_val("wb_ack", 16'd0, wb_ack);
		get_rand(v);
		a[15:8] = v;
		get_rand(v);
		a[7:0] = v;
		set_ba(a);
		read_pair(R_BA_HI, R_BA_LO, got);
		check_val("BA", a, got);
		a = a ^ 16'h5A3C;
		wb_write(R_AA_HI, a[15:8]);
		wb_write(R_AA_LO, a[7:0]);
		read_pair(R_AA_HI, R_AA_LO, got);
		check_val("AA", a, got);
		a = {a[7:0], a[15:8]};
		wb_write(R_DS_HI, a[15:8]);
		wb_write(R_DS_LO, a[7:0]);
		read_pair(R_DS_HI, R_DS_LO, got);
		check_val("DS", a, got);
		end_test("register readback");
	endtask

	task automatic test_write_read();
		logic [7:0]  v;
		logic [15:0] got;
		start_test();
		set_ua(16'h0400);
		for (int i = 0; i < 16; i++) begin
			get_rand(v);
			mem_write(v);
		end
		read_pair(R_UA_HI, R_UA_LO, got);
		check_val("UA after writes", 16'h0410, got);
		set_ua(16'h0400);
		mem_read_check(16);
		read_pair(R_UA_HI, R_UA_LO, got);
		check_val("UA after reads", 16'h0410, got);
		end_test("write then read");
	endtask

	task automatic test_fill();
		logic [7:0]  v;
		logic [7:0]  n;
		logic [15:0] got;
		start_test();
		wb_write(R_MODE, 8'h00);
		set_ua(16'h0800);
		get_rand(v);
		mem_write(v);  // DA write stores one byte before the fill
		get_rand(n);
		n = 8'd1 + (n % 8'd40);
		wb_write(R_WC, n);
		wait_idle();
		model_fill(v, int'(n));
		read_pair(R_UA_HI, R_UA_LO, got);
		check_val("UA after fill", 16'h0801 + 16'(n), got);
		wb_read(R_WC, v);
		check_val("WC after fill", 16'd0, v);
		set_ua(16'h0800);
		mem_read_check(int'(n) + 1);
		end_test("fill");
	endtask

	task automatic test_copy();
		logic [15:0] got;
		start_test();
		wb_write(R_MODE, 8'h04);
		set_ba(16'h0400);
		set_ua(16'h0A00);
		wb_write(R_WC, 8'd16);
		wait_idle();
		model_copy(16);
		read_pair(R_BA_HI, R_BA_LO, got);
		check_val("BA after copy", 16'h0410, got);
		read_pair(R_UA_HI, R_UA_LO, got);
		check_val("UA after copy", 16'h0A10, got);
		wb_write(R_MODE, 8'h00);
		set_ua(16'h0A00);
		mem_read_check(16);
		end_test("copy");
	endtask

	task automatic test_backpressure();
		logic [7:0]  v;
		logic [7:0]  v2;
		logic [15:0] got;
		logic        last_busy;
		logic        acked;
		int          n;
		start_test();
		set_ua(16'h0C00);
		get_rand(v);
		mem_write(v);
		wb_write(R_WC, 8'd200);
		model_fill(v, 200);
		get_rand(v2);
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= R_DA;
		wb_dat_i <= v2;
		last_busy = 1'b1;
		acked     = 1'b0;
		n         = 0;
		while (!acked && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
			if (wb_ack)
				acked = 1'b1;
			else
				last_busy = busy;
		end
		if (!acked)
			report_timeout("DA write during fill never acked");
		bus_release();
		model_write(v2);
		check_val("busy before ack", 16'd0, last_busy);
		check_val("ack held during fill", 16'd1, n > 100);
		wait_idle();
		read_pair(R_UA_HI, R_UA_LO, got);
		check_val("UA after fill and write", ua_sh, got);
		set_ua(16'h0C00 + 16'd195);
		mem_read_check(7);
		end_test("back-pressure");
	endtask

	task automatic test_display();
		localparam int HD     = 8;
		localparam int AI     = 4;
		localparam int CTV    = 7;
		localparam int ROWS   = 2;
		localparam int STRIDE = HD + AI;
		logic [15:0] ds;
		logic [15:0] aa;
		logic [2:0]  cb;
		logic [7:0]  v;
		logic [7:0]  code;
		logic [7:0]  attr;
		start_test();
		ds = 16'h0100;
		aa = 16'h0200;
		cb = 3'd1;  // bitmaps above 0x2000, clear of screen and attributes
		set_ua(ds);
		for (int i = 0; i < ROWS * STRIDE; i++) begin
			get_rand(v);
			mem_write(v);
		end
		set_ua(aa);
		for (int i = 0; i < ROWS * STRIDE; i++) begin
			get_rand(v);
			mem_write(v);
		end
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < HD; c++) begin
				code = mirror_at(ds + 16'(r * STRIDE + c));
				attr = mirror_at(aa + 16'(r * STRIDE + c));
				set_ua(char_addr_of(cb, 1'b1, attr, code, 0));
				for (int l = 0; l <= CTV; l++) begin
					get_rand(v);
					mem_write(v);
				end
			end
		end
		wait_idle();
		wb_write(R_CTV, 8'(CTV));
		wb_write(R_VT, 8'd3);
		wb_write(R_VD, 8'(ROWS));
		wb_write(R_DS_HI, ds[15:8]);
		wb_write(R_DS_LO, ds[7:0]);
		wb_write(R_AA_HI, aa[15:8]);
		wb_write(R_AA_LO, aa[7:0]);
		wb_write(R_CB, {5'b00000, cb});
		wb_write(R_AI, 8'(AI));
		wb_write(R_MODE, 8'h02);
		wb_write(R_HD, 8'(HD));
		wait_frame_start();
		for (int r = 0; r < ROWS; r++) begin
			for (int l = 0; l <= CTV; l++) begin
				for (int c = 0; c < HD; c++) begin
					if (r != 0 || l != 0 || c != 0)
						wait_vid();
					code = mirror_at(ds + 16'(r * STRIDE + c));
					attr = mirror_at(aa + 16'(r * STRIDE + c));
					check_val("vid_code", code, vid_code);
					check_val("vid_attr", attr, vid_attr);
					check_val("vid_bits", mirror_at(char_addr_of(cb, 1'b1, attr, code, l)),
						vid_bits);
				end
			end
		end
		end_test("display fetch");
	endtask

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 6'd0;
		wb_dat_i = 8'd0;
		rng      = 32'd48;
		checks   = 0;
		errors   = 0;
		ua_sh    = 16'h0000;
		ba_sh    = 16'h0000;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		test_regs();
		test_write_read();
		test_fill();
		test_copy();
		test_backpressure();
		test_display();
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
